/* src/vcache_pkg.sv */
package vcache_pkg;

  // geometry
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int MASK_WIDTH = DATA_WIDTH / 8;
  localparam int SETS = 16;
  localparam int BLOCK_WORDS = 4;
  localparam int WAYS = 2;

  localparam int LG_MASK = $clog2(MASK_WIDTH);
  localparam int LG_BLOCK = $clog2(BLOCK_WORDS);
  localparam int LG_SETS = $clog2(SETS);
  // lowest tag bit doubles as way select for tag ops
  localparam int TAG_WIDTH = ADDR_WIDTH - LG_SETS - LG_BLOCK - LG_MASK;

  // opcode class in bits 4:3, size in bits 2:0
  localparam int OPCODE_WIDTH = 5;
  localparam logic [1:0] CLASS_LD = 2'b00;
  localparam logic [1:0] CLASS_ST = 2'b01;
  localparam logic [OPCODE_WIDTH-1:0] TAGST = 5'b10000;
  localparam logic [OPCODE_WIDTH-1:0] TAGLV = 5'b10010;
  localparam logic [OPCODE_WIDTH-1:0] TAGLA = 5'b10011;

  // internal access size code
  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;
  localparam logic [1:0] SIZE_MASK = 2'b11;

  // request data word: store data, or a tag entry for TAGST
  typedef union packed {
    logic [DATA_WIDTH-1:0] word;
    struct packed {
      logic                              valid;
      logic [DATA_WIDTH-TAG_WIDTH-2:0]   unused;
      logic [TAG_WIDTH-1:0]              tag;
    } tag_entry;
  } vcache_word_u;

endpackage

/* src/vcache_decode.sv */
`timescale 1ns/1ps

module vcache_decode
  import vcache_pkg::*;
(
  input  logic [OPCODE_WIDTH-1:0] opcode_i,
  input  logic [ADDR_WIDTH-1:0]   addr_i,
  output logic                    ld_op_o,
  output logic                    st_op_o,
  output logic                    tagst_op_o,
  output logic                    taglv_op_o,
  output logic                    tagla_op_o,
  output logic [1:0]              size_o,
  output logic [TAG_WIDTH-1:0]    tag_o,
  output logic                    way_sel_o,
  output logic [LG_SETS-1:0]      index_o,
  output logic [LG_BLOCK-1:0]     offset_o
);

  // op class
  assign ld_op_o = (opcode_i[4:3] == CLASS_LD);
  assign st_op_o = (opcode_i[4:3] == CLASS_ST);

  assign tagst_op_o = (opcode_i == TAGST);
  assign taglv_op_o = (opcode_i == TAGLV);
  assign tagla_op_o = (opcode_i == TAGLA);

  // unknown size fields fall back to a word access
  always_comb begin
    case (opcode_i[2:0])
      3'b000:  size_o = SIZE_BYTE;
      3'b001:  size_o = SIZE_HALF;
      3'b100:  size_o = SIZE_MASK;
      default: size_o = SIZE_WORD;
    endcase
  end

  // address is tag | index | word offset | byte offset
  assign tag_o = addr_i[LG_MASK+LG_BLOCK+LG_SETS +: TAG_WIDTH];
  assign index_o = addr_i[LG_MASK+LG_BLOCK +: LG_SETS];
  assign offset_o = addr_i[LG_MASK +: LG_BLOCK];
  assign way_sel_o = tag_o[0];

endmodule

/* src/vcache_ram.sv */
`timescale 1ns/1ps

module vcache_ram #(
  parameter int WIDTH = 32,
  parameter int ELS = 16
) (
  input  logic                    clk_i,
  input  logic                    v_i,
  input  logic                    w_i,
  input  logic [$clog2(ELS)-1:0]  addr_i,
  input  logic [WIDTH-1:0]        data_i,
  input  logic [WIDTH-1:0]        w_mask_i,
  output logic [WIDTH-1:0]        data_o
);

  logic [WIDTH-1:0] mem [ELS];

  // one access per cycle, read data held until the next read
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        mem[addr_i] <= (mem[addr_i] & ~w_mask_i) | (data_i & w_mask_i);
      end else begin
        data_o <= mem[addr_i];
      end
    end
  end

endmodule

/* src/vcache_lookup.sv */
`timescale 1ns/1ps

module vcache_lookup
  import vcache_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  accept_i,
  input  logic                                  advance_v_i,
  input  logic                                  ld_op_i,
  input  logic                                  st_op_i,
  input  logic                                  tagst_op_i,
  input  logic                                  taglv_op_i,
  input  logic                                  tagla_op_i,
  input  logic [1:0]                            size_i,
  input  logic [TAG_WIDTH-1:0]                  tag_i,
  input  logic                                  way_sel_i,
  input  logic [LG_SETS-1:0]                    index_i,
  input  logic [LG_BLOCK-1:0]                   offset_i,
  input  logic                                  sigext_i,
  input  logic [MASK_WIDTH-1:0]                 mask_i,
  input  logic [ADDR_WIDTH-1:0]                 addr_i,
  input  vcache_word_u                          data_i,
  output logic                                  tl_valid_o,
  output logic                                  v_valid_o,
  output logic                                  st_pending_o,
  output logic                                  v_ld_o,
  output logic                                  v_st_o,
  output logic                                  v_taglv_o,
  output logic                                  v_tagla_o,
  output logic [1:0]                            v_size_o,
  output logic                                  v_sigext_o,
  output logic [MASK_WIDTH-1:0]                 v_mask_o,
  output logic [ADDR_WIDTH-1:0]                 v_addr_o,
  output logic [WAYS-1:0]                       hit_o,
  output logic [WAYS-1:0]                       v_valid_bits_o,
  output logic [WAYS-1:0][TAG_WIDTH-1:0]        v_tags_o,
  output logic [WAYS-1:0][DATA_WIDTH-1:0]       v_word_o
);

  localparam int ENTRY_WIDTH = TAG_WIDTH + 1;

  logic tl_ld, tl_st, tl_taglv, tl_tagla, tl_sigext;
  logic [1:0] tl_size;
  logic [MASK_WIDTH-1:0] tl_mask;
  logic [ADDR_WIDTH-1:0] tl_addr;
  logic [TAG_WIDTH-1:0] tl_tag;
  vcache_word_u tl_data;
  logic [TAG_WIDTH-1:0] v_tag;
  vcache_word_u v_data;

  logic tag_w;
  logic [WAYS*ENTRY_WIDTH-1:0] tag_w_mask;
  logic [WAYS*ENTRY_WIDTH-1:0] tag_rd;
  logic [WAYS-1:0] tl_rd_valid;
  logic [WAYS-1:0][TAG_WIDTH-1:0] tl_rd_tags;

  logic st_write;
  logic st_way;
  logic [DATA_WIDTH-1:0] st_data;
  logic [MASK_WIDTH-1:0] st_bmask;
  logic [DATA_WIDTH-1:0] st_bits;
  logic [WAYS*DATA_WIDTH-1:0] data_w_mask;
  logic [LG_SETS+LG_BLOCK-1:0] data_addr;
  logic [WAYS*DATA_WIDTH-1:0] data_rd;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_valid_o <= 1'b0;
      v_valid_o <= 1'b0;
    end else begin
      if (accept_i) begin
        tl_valid_o <= 1'b1;
      end else if (advance_v_i) begin
        tl_valid_o <= 1'b0;
      end
      if (advance_v_i) begin
        v_valid_o <= tl_valid_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      {tl_ld, tl_st, tl_taglv, tl_tagla} <= {ld_op_i, st_op_i, taglv_op_i, tagla_op_i};
      tl_size <= size_i;
      tl_sigext <= sigext_i;
      tl_mask <= mask_i;
      tl_addr <= addr_i;
      tl_tag <= tag_i;
      tl_data <= data_i;
    end
    // arrays were read on the accept edge, capture them as tl moves on
    if (advance_v_i && tl_valid_o) begin
      {v_ld_o, v_st_o, v_taglv_o, v_tagla_o} <= {tl_ld, tl_st, tl_taglv, tl_tagla};
      v_size_o <= tl_size;
      v_sigext_o <= tl_sigext;
      v_mask_o <= tl_mask;
      v_addr_o <= tl_addr;
      v_tag <= tl_tag;
      v_data <= tl_data;
      v_valid_bits_o <= tl_rd_valid;
      v_tags_o <= tl_rd_tags;
      v_word_o <= data_rd;
    end
  end

  assign st_pending_o = (tl_valid_o & tl_st) | (v_valid_o & v_st_o);

  // tag array, one {valid, tag} entry per way
  assign tag_w = accept_i & tagst_op_i;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      tag_w_mask[w*ENTRY_WIDTH +: ENTRY_WIDTH] = {ENTRY_WIDTH{int'(way_sel_i) == w}};
      tl_rd_valid[w] = tag_rd[w*ENTRY_WIDTH+TAG_WIDTH];
      tl_rd_tags[w] = tag_rd[w*ENTRY_WIDTH +: TAG_WIDTH];
      hit_o[w] = v_valid_bits_o[w] & (v_tags_o[w] == v_tag);
    end
  end

  vcache_ram #(
    .WIDTH(WAYS*ENTRY_WIDTH),
    .ELS(SETS)
  ) tag_ram_i (
    .clk_i(clk_i), .v_i(accept_i), .w_i(tag_w), .addr_i(index_i),
    .data_i({WAYS{data_i.tag_entry.valid, data_i.tag_entry.tag}}),
    .w_mask_i(tag_w_mask), .data_o(tag_rd)
  );

  // store hit writes as it is consumed, way 1 wins a double hit
  assign st_write = v_valid_o & v_st_o & advance_v_i & (|hit_o);
  assign st_way = hit_o[1];

  always_comb begin
    case (v_size_o)
      SIZE_BYTE: st_data = {MASK_WIDTH{v_data.word[7:0]}};
      SIZE_HALF: st_data = {2{v_data.word[DATA_WIDTH/2-1:0]}};
      default:   st_data = v_data.word;
    endcase
    case (v_size_o)
      SIZE_BYTE: st_bmask = MASK_WIDTH'(1) << v_addr_o[LG_MASK-1:0];
      SIZE_HALF: st_bmask = MASK_WIDTH'({(MASK_WIDTH/2){1'b1}})
                            << (MASK_WIDTH / 2 * v_addr_o[LG_MASK-1]);
      SIZE_MASK: st_bmask = v_mask_o;
      default:   st_bmask = '1;
    endcase
    for (int b = 0; b < MASK_WIDTH; b++) begin
      st_bits[8*b +: 8] = {8{st_bmask[b]}};
    end
    for (int w = 0; w < WAYS; w++) begin
      data_w_mask[w*DATA_WIDTH +: DATA_WIDTH] = (int'(st_way) == w) ? st_bits : '0;
    end
  end

  assign data_addr = st_write ? v_addr_o[LG_MASK +: LG_SETS+LG_BLOCK] : {index_i, offset_i};

  vcache_ram #(
    .WIDTH(WAYS*DATA_WIDTH),
    .ELS(SETS*BLOCK_WORDS)
  ) data_ram_i (
    .clk_i(clk_i), .v_i((accept_i & ld_op_i) | st_write), .w_i(st_write),
    .addr_i(data_addr), .data_i({WAYS{st_data}}),
    .w_mask_i(data_w_mask), .data_o(data_rd)
  );

endmodule

/* src/vcache_pipe_ctrl.sv */
`timescale 1ns/1ps

module vcache_pipe_ctrl (
  input  logic v_i,
  input  logic yumi_i,
  input  logic ld_op_i,
  input  logic tl_valid_i,
  input  logic v_valid_i,
  input  logic st_pending_i,
  output logic ready_o,
  output logic accept_o,
  output logic advance_v_o,
  output logic v_o
);

  logic tl_ready;
  logic ld_stall;

  // result sits in the v stage until consumed
  assign v_o = v_valid_i;

  // v stage moves when empty or being consumed
  assign advance_v_o = ~v_valid_i | yumi_i;

  assign tl_ready = ~tl_valid_i | advance_v_o;

  // no load past an unwritten store, this also keeps the data array single-port
  assign ld_stall = ld_op_i & st_pending_i;

  assign ready_o = tl_ready & ~ld_stall;
  assign accept_o = v_i & ready_o;

endmodule

/* src/vcache_load_align.sv */
`timescale 1ns/1ps

module vcache_load_align
  import vcache_pkg::*;
(
  input  logic                              v_valid_i,
  input  logic                              v_ld_i,
  input  logic                              v_st_i,
  input  logic                              v_taglv_i,
  input  logic                              v_tagla_i,
  input  logic [1:0]                        v_size_i,
  input  logic                              v_sigext_i,
  input  logic [MASK_WIDTH-1:0]             v_mask_i,
  input  logic [ADDR_WIDTH-1:0]             v_addr_i,
  input  logic [WAYS-1:0]                   v_valid_bits_i,
  input  logic [WAYS-1:0][TAG_WIDTH-1:0]    v_tags_i,
  input  logic [WAYS-1:0][DATA_WIDTH-1:0]   v_word_i,
  input  logic [WAYS-1:0]                   hit_i,
  output logic [DATA_WIDTH-1:0]             data_o,
  output logic                              miss_o
);

  logic way_sel;
  logic [LG_SETS-1:0] index;
  logic any_hit;
  logic [DATA_WIDTH-1:0] word;
  logic [DATA_WIDTH-1:0] masked;
  logic [DATA_WIDTH/2-1:0] half_sel;
  logic [7:0] byte_sel;

  assign way_sel = v_addr_i[LG_MASK+LG_BLOCK+LG_SETS];
  assign index = v_addr_i[LG_MASK+LG_BLOCK +: LG_SETS];
  assign any_hit = |hit_i;

  assign miss_o = v_valid_i & (v_ld_i | v_st_i) & ~any_hit;

  // way 1 wins a double hit
  assign word = hit_i[1] ? v_word_i[1] : v_word_i[0];
  assign half_sel = word[(DATA_WIDTH/2)*v_addr_i[LG_MASK-1] +: DATA_WIDTH/2];
  assign byte_sel = word[8*v_addr_i[LG_MASK-1:0] +: 8];

  always_comb begin
    for (int b = 0; b < MASK_WIDTH; b++) begin
      masked[8*b +: 8] = word[8*b +: 8] & {8{v_mask_i[b]}};
    end
  end

  // stores and misses return zero
  always_comb begin
    data_o = '0;
    if (v_taglv_i) begin
      data_o = DATA_WIDTH'(v_valid_bits_i[way_sel]);
    end else if (v_tagla_i) begin
      data_o = DATA_WIDTH'({v_tags_i[way_sel], index, {(LG_BLOCK+LG_MASK){1'b0}}});
    end else if (v_ld_i && any_hit) begin
      case (v_size_i)
        SIZE_BYTE: data_o = {{(DATA_WIDTH-8){v_sigext_i & byte_sel[7]}}, byte_sel};
        SIZE_HALF: data_o = {{(DATA_WIDTH/2){v_sigext_i & half_sel[DATA_WIDTH/2-1]}},
                             half_sel};
        SIZE_MASK: data_o = masked;
        default:   data_o = word;
      endcase
    end
  end

endmodule

/* src/vcache_top.sv */
`timescale 1ns/1ps

module vcache_top
  import vcache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    v_i,
  input  logic [OPCODE_WIDTH-1:0] opcode_i,
  input  logic                    sigext_i,
  input  logic [MASK_WIDTH-1:0]   mask_i,
  input  logic [ADDR_WIDTH-1:0]   addr_i,
  input  logic [DATA_WIDTH-1:0]   data_i,
  output logic                    ready_o,
  output logic                    v_o,
  output logic [DATA_WIDTH-1:0]   data_o,
  output logic                    miss_o,
  input  logic                    yumi_i
);

  logic ld_op, st_op, tagst_op, taglv_op, tagla_op;
  logic [1:0] size;
  logic [TAG_WIDTH-1:0] tag;
  logic way_sel;
  logic [LG_SETS-1:0] index;
  logic [LG_BLOCK-1:0] offset;

  logic accept, advance_v;
  logic tl_valid, v_valid, st_pending;

  logic v_ld, v_st, v_taglv, v_tagla, v_sigext;
  logic [1:0] v_size;
  logic [MASK_WIDTH-1:0] v_mask;
  logic [ADDR_WIDTH-1:0] v_addr;
  logic [WAYS-1:0] hit;
  logic [WAYS-1:0] v_valid_bits;
  logic [WAYS-1:0][TAG_WIDTH-1:0] v_tags;
  logic [WAYS-1:0][DATA_WIDTH-1:0] v_word;

  vcache_decode decode_i (
    .opcode_i(opcode_i), .addr_i(addr_i),
    .ld_op_o(ld_op), .st_op_o(st_op), .tagst_op_o(tagst_op),
    .taglv_op_o(taglv_op), .tagla_op_o(tagla_op), .size_o(size),
    .tag_o(tag), .way_sel_o(way_sel), .index_o(index), .offset_o(offset)
  );

  vcache_lookup lookup_i (
    .clk_i(clk_i), .reset_i(reset_i), .accept_i(accept), .advance_v_i(advance_v),
    .ld_op_i(ld_op), .st_op_i(st_op), .tagst_op_i(tagst_op),
    .taglv_op_i(taglv_op), .tagla_op_i(tagla_op), .size_i(size),
    .tag_i(tag), .way_sel_i(way_sel), .index_i(index), .offset_i(offset),
    .sigext_i(sigext_i), .mask_i(mask_i), .addr_i(addr_i), .data_i(data_i),
    .tl_valid_o(tl_valid), .v_valid_o(v_valid), .st_pending_o(st_pending),
    .v_ld_o(v_ld), .v_st_o(v_st), .v_taglv_o(v_taglv), .v_tagla_o(v_tagla),
    .v_size_o(v_size), .v_sigext_o(v_sigext), .v_mask_o(v_mask), .v_addr_o(v_addr),
    .hit_o(hit), .v_valid_bits_o(v_valid_bits), .v_tags_o(v_tags), .v_word_o(v_word)
  );

  vcache_pipe_ctrl pipe_ctrl_i (
    .v_i(v_i), .yumi_i(yumi_i), .ld_op_i(ld_op),
    .tl_valid_i(tl_valid), .v_valid_i(v_valid), .st_pending_i(st_pending),
    .ready_o(ready_o), .accept_o(accept), .advance_v_o(advance_v), .v_o(v_o)
  );

  vcache_load_align load_align_i (
    .v_valid_i(v_valid), .v_ld_i(v_ld), .v_st_i(v_st),
    .v_taglv_i(v_taglv), .v_tagla_i(v_tagla), .v_size_i(v_size),
    .v_sigext_i(v_sigext), .v_mask_i(v_mask), .v_addr_i(v_addr),
    .v_valid_bits_i(v_valid_bits), .v_tags_i(v_tags), .v_word_i(v_word),
    .hit_i(hit), .data_o(data_o), .miss_o(miss_o)
  );

endmodule

/* verif/vcache_sva.sv */
`timescale 1ns/1ps

module vcache_sva
  import vcache_pkg::*;
(
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  v_o,
  input logic                  yumi_i,
  input logic [DATA_WIDTH-1:0] data_o,
  input logic                  miss_o
);

  // pipeline comes out of reset empty
  reset_empty_a: assert property (@(posedge clk_i) reset_i |=> !v_o)
    else $error("v_o high on the cycle after reset");

  miss_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_o |-> data_o == '0)
    else $error("data_o not zero on a miss");

  // result held under back-pressure
  hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(data_o) && $stable(miss_o))
    else $error("result changed while waiting for yumi_i");

endmodule

/* verif/vcache_tb.sv */
`timescale 1ns/1ps

module vcache_tb;
  import vcache_pkg::*;

  localparam int CLK_NS = 100;
  localparam int IDX_LSB = LG_MASK + LG_BLOCK;
  localparam int TAG_LSB = IDX_LSB + LG_SETS;
  localparam int N_INIT = SETS * WAYS * (1 + BLOCK_WORDS);
  localparam int N_TAG = 8;
  localparam int N_WORD = 16;
  localparam int N_SUB = 32;
  localparam int N_MISS = 8;
  localparam int N_RAND = 150;
  localparam int N_TOTAL = N_INIT + 4 * N_TAG + 2 * N_WORD + 2 * N_SUB + 3 * N_MISS
                           + 2 * N_RAND;

  logic clk_i, reset_i, v_i, sigext_i, yumi_i, ready_o, v_o, miss_o;
  logic [OPCODE_WIDTH-1:0] opcode_i;
  logic [MASK_WIDTH-1:0] mask_i;
  logic [ADDR_WIDTH-1:0] addr_i;
  vcache_word_u data_i;
  logic [DATA_WIDTH-1:0] data_o;

  // reference state
  logic ref_valid [SETS][WAYS];
  logic [TAG_WIDTH-1:0] ref_tag [SETS][WAYS];
  logic [DATA_WIDTH-1:0] ref_data [SETS][WAYS][BLOCK_WORDS];

  vcache_word_u exp_word_q[$];
  logic exp_miss_q[$];
  time acc_time_q[$];
  string what_q[$];
  bit random_yumi;
  int errors, n_results, res_mark, err_mark, seed_ret;

  vcache_top dut_i (.*);

  bind vcache_top vcache_sva sva_i (
    .clk_i(clk_i), .reset_i(reset_i), .v_o(v_o), .yumi_i(yumi_i),
    .data_o(data_o), .miss_o(miss_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  initial begin
    yumi_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      yumi_i = random_yumi ? 1'($urandom) : 1'b1;
    end
  end

  initial begin
    #(CLK_NS * (N_TOTAL * 20 + 10));
    $display("timeout: results still missing after %0d requests' worth of cycles", N_TOTAL);
    $display("sim failed");
    $finish;
  end

  function automatic logic [ADDR_WIDTH-1:0] make_addr(logic [TAG_WIDTH-1:0] tag, int s,
                                                      int off, int b);
    return {tag, LG_SETS'(s), LG_BLOCK'(off), LG_MASK'(b)};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] line_addr(int s, int w, int off, int b);
    return make_addr(ref_tag[s][w], s, off, b);
  endfunction

  // tag ops pick the way with the lowest tag bit
  function automatic logic [ADDR_WIDTH-1:0] tagop_addr(int s, int w);
    return make_addr(TAG_WIDTH'(w), s, 0, 0);
  endfunction

  function automatic vcache_word_u tag_entry(logic valid, logic [TAG_WIDTH-1:0] tag);
    vcache_word_u e;
    e.word = '0;
    e.tag_entry.valid = valid;
    e.tag_entry.tag = tag;
    return e;
  endfunction

  function automatic logic [OPCODE_WIDTH-1:0] mem_op(logic st, int sz);
    logic [2:0] size_bits;
    size_bits = (sz == 3) ? 3'b100 : 3'(sz);
    return {st ? CLASS_ST : CLASS_LD, size_bits};
  endfunction

  function automatic vcache_word_u predict(logic [OPCODE_WIDTH-1:0] op,
                                           logic [ADDR_WIDTH-1:0] addr,
                                           logic [MASK_WIDTH-1:0] mask, logic sext,
                                           output logic miss);
    int s;
    int way;
    logic [TAG_WIDTH-1:0] tag;
    logic [WAYS-1:0] hit;
    logic [DATA_WIDTH-1:0] word, masked;
    logic [7:0] b;
    logic [15:0] h;
    vcache_word_u res;
    tag = addr[TAG_LSB +: TAG_WIDTH];
    s = int'(addr[IDX_LSB +: LG_SETS]);
    way = int'(tag[0]);
    for (int w = 0; w < WAYS; w++) begin
      hit[w] = ref_valid[s][w] && ref_tag[s][w] == tag;
    end
    word = ref_data[s][hit[1] ? 1 : 0][int'(addr[LG_MASK +: LG_BLOCK])];
    b = word[8 * addr[1:0] +: 8];
    h = word[16 * addr[1] +: 16];
    for (int i = 0; i < MASK_WIDTH; i++) begin
      masked[8 * i +: 8] = word[8 * i +: 8] & {8{mask[i]}};
    end
    res.word = '0;
    miss = 1'b0;
    if (op == TAGLV) begin
      res.word = DATA_WIDTH'(ref_valid[s][way]);
    end else if (op == TAGLA) begin
      res.word = DATA_WIDTH'({ref_tag[s][way], addr[IDX_LSB +: LG_SETS], 4'b0000});
    end else if (op[4:3] == CLASS_LD || op[4:3] == CLASS_ST) begin
      miss = (hit == '0);
      if (op[4:3] == CLASS_LD && !miss) begin
        case (op[2:0])
          3'b000:  res.word = {{24{sext & b[7]}}, b};
          3'b001:  res.word = {{16{sext & h[15]}}, h};
          3'b100:  res.word = masked;
          default: res.word = word;
        endcase
      end
    end
    return res;
  endfunction

  function automatic void apply_to_model(logic [OPCODE_WIDTH-1:0] op,
                                         logic [ADDR_WIDTH-1:0] addr, vcache_word_u data,
                                         logic [MASK_WIDTH-1:0] mask);
    int s;
    int off;
    int way;
    logic [TAG_WIDTH-1:0] tag;
    logic [MASK_WIDTH-1:0] bmask;
    logic [DATA_WIDTH-1:0] rep;
    tag = addr[TAG_LSB +: TAG_WIDTH];
    s = int'(addr[IDX_LSB +: LG_SETS]);
    off = int'(addr[LG_MASK +: LG_BLOCK]);
    way = -1;
    if (op == TAGST) begin
      ref_valid[s][int'(tag[0])] = data.tag_entry.valid;
      ref_tag[s][int'(tag[0])] = data.tag_entry.tag;
    end else if (op[4:3] == CLASS_ST) begin
      // way 1 takes a double hit
      if (ref_valid[s][1] && ref_tag[s][1] == tag) begin
        way = 1;
      end else if (ref_valid[s][0] && ref_tag[s][0] == tag) begin
        way = 0;
      end
      case (op[2:0])
        3'b000:  bmask = 4'b0001 << addr[1:0];
        3'b001:  bmask = addr[1] ? 4'b1100 : 4'b0011;
        3'b100:  bmask = mask;
        default: bmask = 4'b1111;
      endcase
      case (op[2:0])
        3'b000:  rep = {4{data.word[7:0]}};
        3'b001:  rep = {2{data.word[15:0]}};
        default: rep = data.word;
      endcase
      for (int i = 0; i < MASK_WIDTH; i++) begin
        if (way >= 0 && bmask[i]) begin
          ref_data[s][way][off][8 * i +: 8] = rep[8 * i +: 8];
        end
      end
    end
  endfunction

  task automatic check_word(vcache_word_u got, vcache_word_u exp, string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s data_o %h, expected %h", $time, what, got.word, exp.word);
      errors++;
    end
  endtask

  task automatic check_miss(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s miss_o %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_ready(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s ready_o %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // called a little after a rising edge, returns the same way
  task automatic issue(logic [OPCODE_WIDTH-1:0] op, logic [ADDR_WIDTH-1:0] addr,
                       vcache_word_u data, logic [MASK_WIDTH-1:0] mask, logic sext);
    logic exp_miss;
    vcache_word_u exp_word;
    v_i = 1'b1;
    opcode_i = op;
    addr_i = addr;
    data_i = data;
    mask_i = mask;
    sigext_i = sext;
    do begin
      @(negedge clk_i);
    end while (!ready_o);
    exp_word = predict(op, addr, mask, sext, exp_miss);
    apply_to_model(op, addr, data, mask);
    exp_word_q.push_back(exp_word);
    exp_miss_q.push_back(exp_miss);
    acc_time_q.push_back(random_yumi ? 0 : $time);
    what_q.push_back($sformatf("opcode %b addr %h", op, addr));
    @(posedge clk_i);
    #1;
    v_i = 1'b0;
  endtask

  task automatic idle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic pick_line(output int s, output int w);
    do begin
      s = int'($urandom_range(SETS - 1));
      w = int'($urandom_range(WAYS - 1));
    end while (!ref_valid[s][w]);
  endtask

  task automatic random_request();
    int kind;
    int s;
    int w;
    logic [ADDR_WIDTH-1:0] a;
    kind = int'($urandom_range(9));
    s = int'($urandom_range(SETS - 1));
    w = int'($urandom_range(WAYS - 1));
    a = line_addr(s, w, int'($urandom_range(BLOCK_WORDS - 1)),
                  int'($urandom_range(MASK_WIDTH - 1)));
    // now and then a tag nobody holds
    if ($urandom_range(7) == 0) begin
      a[TAG_LSB +: TAG_WIDTH] = TAG_WIDTH'($urandom);
    end
    if (kind < 4) begin
      issue(mem_op(1'b0, kind), a, '0, MASK_WIDTH'($urandom), 1'($urandom));
    end else if (kind < 8) begin
      issue(mem_op(1'b1, kind - 4), a, $urandom, MASK_WIDTH'($urandom), 1'b0);
    end else if (kind == 8) begin
      issue($urandom_range(1) ? TAGLV : TAGLA, a, '0, '0, 1'b0);
    end else begin
      issue(TAGST, tagop_addr(s, w), tag_entry($urandom_range(3) != 0, TAG_WIDTH'($urandom)),
            '0, 1'b0);
    end
  endtask

  task automatic finish_test(string name);
    while (exp_word_q.size() != 0) begin
      @(negedge clk_i);
    end
    $display("%s: %0d results, %0d errors", name, n_results - res_mark, errors - err_mark);
    res_mark = n_results;
    err_mark = errors;
    idle();
  endtask

  initial begin : compare_results
    vcache_word_u exp_word;
    logic exp_miss;
    time t_acc;
    string what;
    forever begin
      @(negedge clk_i);
      if (!reset_i && v_o && yumi_i) begin
        if (exp_word_q.size() == 0) begin
          $display("result at %0t arrived with no request outstanding", $time);
          errors++;
        end else begin
          exp_word = exp_word_q.pop_front();
          exp_miss = exp_miss_q.pop_front();
          t_acc = acc_time_q.pop_front();
          what = what_q.pop_front();
          check_word(data_o, exp_word, what);
          check_miss(miss_o, exp_miss, what);
          n_results++;
          if (t_acc != 0 && ($time - t_acc) != 2 * CLK_NS) begin
            $display("ERROR %0t: %s took %0t ns from accept, expected 2 cycles",
                     $time, what, $time - t_acc);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    int s;
    int w;
    int off;
    int sz;
    logic [TAG_WIDTH-1:0] t;
    logic [ADDR_WIDTH-1:0] a;
    seed_ret = $urandom(32'h98e1_94ce);
    random_yumi = 1'b0;
    reset_i = 1'b1;
    v_i = 1'b0;
    opcode_i = '0;
    sigext_i = 1'b0;
    mask_i = '0;
    addr_i = '0;
    data_i = '0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_ready(ready_o, 1'b1, "after reset");
    idle();

    // every line valid with a known fill, tags first so no lookup sees an unwritten entry
    for (s = 0; s < SETS; s++) begin
      for (w = 0; w < WAYS; w++) begin
        issue(TAGST, tagop_addr(s, w), tag_entry(1'b1, TAG_WIDTH'(2 * s + w)), '0, 1'b0);
      end
    end
    for (s = 0; s < SETS; s++) begin
      for (w = 0; w < WAYS; w++) begin
        for (off = 0; off < BLOCK_WORDS; off++) begin
          a = line_addr(s, w, off, 0);
          issue(mem_op(1'b1, 2), a, {a, ~a} ^ 32'h3c5a_e18d, '1, 1'b0);
        end
      end
    end
    finish_test("setup");

    for (int i = 0; i < N_TAG; i++) begin
      s = int'($urandom_range(SETS - 1));
      for (w = 0; w < WAYS; w++) begin
        issue(TAGST, tagop_addr(s, w),
              tag_entry($urandom_range(3) != 0, TAG_WIDTH'($urandom)), '0, 1'b0);
      end
      issue(TAGLV, tagop_addr(s, int'($urandom_range(1))), '0, '0, 1'b0);
      issue(TAGLA, tagop_addr(s, int'($urandom_range(1))), '0, '0, 1'b0);
    end
    finish_test("test 1 tag ops");

    for (int i = 0; i < N_WORD; i++) begin
      pick_line(s, w);
      a = line_addr(s, w, int'($urandom_range(BLOCK_WORDS - 1)), 0);
      issue(mem_op(1'b1, 2), a, $urandom, '0, 1'b0);
      // a load right behind the store has to wait
      opcode_i = mem_op(1'b0, 2);
      @(negedge clk_i);
      check_ready(ready_o, 1'b0, "load behind store");
      issue(mem_op(1'b0, 2), a, '0, '0, 1'b0);
    end
    finish_test("test 2 word store then load");

    for (int i = 0; i < N_SUB; i++) begin
      pick_line(s, w);
      off = int'($urandom_range(BLOCK_WORDS - 1));
      sz = int'($urandom_range(2));
      if (sz == 2) begin
        sz = 3;
      end
      issue(mem_op(1'b1, sz), line_addr(s, w, off, int'($urandom_range(3))), $urandom,
            MASK_WIDTH'($urandom), 1'b0);
      issue(mem_op(1'b0, int'($urandom_range(3))), line_addr(s, w, off, int'($urandom_range(3))),
            '0, MASK_WIDTH'($urandom), 1'($urandom));
    end
    finish_test("test 3 byte, half and mask");

    for (int i = 0; i < N_MISS; i++) begin
      s = int'($urandom_range(SETS - 1));
      w = int'($urandom_range(WAYS - 1));
      off = int'($urandom_range(BLOCK_WORDS - 1));
      t = TAG_WIDTH'($urandom);
      issue(TAGST, tagop_addr(s, w), tag_entry(1'b0, t), '0, 1'b0);
      issue(mem_op(1'b1, 2), make_addr(t, s, off, 0), $urandom, '0, 1'b0);
      issue(mem_op(1'b0, 2), line_addr(s, 1 - w, off, 0), '0, '0, 1'b0);
    end
    finish_test("test 4 misses");

    random_yumi = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      repeat (int'($urandom_range(2))) idle();
      random_request();
    end
    finish_test("test 5a random back-pressure");
    random_yumi = 1'b0;
    for (int i = 0; i < N_RAND; i++) begin
      random_request();
    end
    finish_test("test 5b streaming latency");

    $display("%0d results checked, %0d errors", n_results, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* vcache_lite.f */
src/vcache_pkg.sv
src/vcache_decode.sv
src/vcache_ram.sv
src/vcache_lookup.sv
src/vcache_pipe_ctrl.sv
src/vcache_load_align.sv
src/vcache_top.sv
verif/vcache_sva.sv
verif/vcache_tb.sv

/* Makefile */
SIM     := verilator
TOP     := vcache_tb
FLIST   := vcache_lite.f
VFLAGS  := --binary --timing --assert -j 0
OBJ_DIR := obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
